/* rtl/x86_decode_pkg.sv */
`default_nettype none

package x86_decode_pkg;

    localparam int QUEUE_BYTES  = 32;
    localparam int WINDOW_BYTES = 16;
    localparam int CHUNK_BYTES  = 8;

    typedef logic [7:0]                  byte_t;
    typedef logic [WINDOW_BYTES*8-1:0]   window_t;
    typedef logic [CHUNK_BYTES*8-1:0]    chunk_t;
    typedef logic [3:0]                  len_t;
    typedef logic [2:0]                  sel_t;
    typedef logic [5:0]                  count_t;

    // immediate and memory offset size codes
    localparam logic [1:0] SIZE_1B = 2'b00;
    localparam logic [1:0] SIZE_2B = 2'b01;
    localparam logic [1:0] SIZE_4B = 2'b10;

    // displacement size code
    localparam logic DISP_32 = 1'b0;
    localparam logic DISP_8  = 1'b1;

    // field decoder to length decoder
    typedef struct packed {
        logic       prefix_present;
        logic [1:0] prefix_size;
        logic       opcode_size;
        logic       modrm_present;
        logic       sib_present;
        logic       offset_present;
        logic [1:0] offset_size;
        logic       disp_present;
        logic       disp_size;
        logic       imm_present;
        logic [1:0] imm_size;
        logic       illegal;
        byte_t      opcode;
        byte_t      modrm;
        logic       has_opsize;
        logic       rep;
    } field_desc_t;

    typedef struct packed {
        sel_t disp_sel;
        len_t imm_sel;
        len_t length;
    } len_info_t;

    // one record per decoded instruction, moffs lands in imm
    typedef struct packed {
        len_t        length;
        byte_t       opcode;
        logic        two_byte;
        byte_t       modrm;
        logic        has_modrm;
        logic        illegal;
        logic [31:0] disp;
        logic [31:0] imm;
        logic        has_disp;
        logic        has_imm;
    } decoded_insn_t;

    typedef enum logic {
        EMPTY,
        FULL
    } extract_state_e;

endpackage

`default_nettype wire

/* rtl/fetch_queue.sv */
`default_nettype none

module fetch_queue
    import x86_decode_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    fetch_valid,
    input  chunk_t  fetch_chunk,
    output logic    fetch_ready,
    input  logic    advance,
    input  len_t    length,
    output window_t window,
    output count_t  avail
);

    // pointers wrap on their own since the depth is a power of two
    typedef logic [$clog2(QUEUE_BYTES)-1:0] qptr_t;

    byte_t  mem [QUEUE_BYTES];
    qptr_t  wr_ptr;
    qptr_t  rd_ptr;
    count_t count;
    logic   push;
    count_t count_in;
    count_t count_out;

    // room for a whole chunk
    assign fetch_ready = (count <= count_t'(QUEUE_BYTES - CHUNK_BYTES));
    assign push        = fetch_valid && fetch_ready;

    assign count_in  = push ? count_t'(CHUNK_BYTES) : '0;
    assign count_out = advance ? count_t'(length) : '0;

    assign avail = count;

    // chunk byte 0 goes to the write pointer
    always_ff @(posedge clk) begin
        if (push) begin
            for (int i = 0; i < CHUNK_BYTES; i++) begin
                mem[wr_ptr + qptr_t'(i)] <= fetch_chunk[i*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + qptr_t'(CHUNK_BYTES);
            end
            if (advance) begin
                rd_ptr <= rd_ptr + qptr_t'(length);
            end
            // push and pop may land on the same edge
            count <= count + count_in - count_out;
        end
    end

    // rotated view, window byte 0 is the head of the queue
    always_comb begin
        for (int i = 0; i < WINDOW_BYTES; i++) begin
            window[i*8 +: 8] = mem[rd_ptr + qptr_t'(i)];
        end
    end

    // decode only consumes bytes that are already here
    a_advance_within_avail: assert property (
        @(posedge clk) disable iff (!rst_n)
        advance |-> (count_t'(length) <= avail)
    ) else $error("advance by %0d with only %0d bytes queued", length, avail);

endmodule

`default_nettype wire

/* rtl/field_decoder.sv */
`default_nettype none

module field_decoder
    import x86_decode_pkg::*;
(
    input  window_t     window,
    input  count_t      avail,
    output field_desc_t fields
);

    byte_t      b [WINDOW_BYTES];
    logic [2:0] pfx;
    logic [1:0] pcount;
    logic       opsize;
    logic       rep;
    len_t       op_pos;
    len_t       modrm_pos;
    byte_t      op0;
    byte_t      opcode;
    byte_t      modrm;
    byte_t      sib;
    logic       two_byte;
    logic       known;
    logic       need_modrm;
    logic       imm_on;
    logic       off_on;
    logic [1:0] imm_code;
    logic [1:0] mod;
    logic [2:0] rm;
    logic       sib_on;

    function automatic logic is_prefix(byte_t v);
        case (v)
            8'h66, 8'h26, 8'h2e, 8'h36, 8'h3e, 8'h64, 8'h65, 8'hf2, 8'hf3: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // bytes not yet queued read as zero
    always_comb begin
        for (int i = 0; i < WINDOW_BYTES; i++) begin
            b[i] = (count_t'(i) < avail) ? window[i*8 +: 8] : 8'h00;
        end
    end

    // leading prefix run, a fourth one is left as the opcode
    always_comb begin
        pfx[0] = is_prefix(b[0]);
        pfx[1] = pfx[0] && is_prefix(b[1]);
        pfx[2] = pfx[1] && is_prefix(b[2]);
        pcount = 2'(pfx[0]) + 2'(pfx[1]) + 2'(pfx[2]);
        opsize = 1'b0;
        rep    = 1'b0;
        for (int i = 0; i < 3; i++) begin
            opsize |= pfx[i] && (b[i] == 8'h66);
            rep    |= pfx[i] && (b[i] == 8'hf2 || b[i] == 8'hf3);
        end
    end

    always_comb begin
        op_pos    = len_t'(pcount);
        op0       = b[op_pos];
        two_byte  = (op0 == 8'h0f);
        opcode    = two_byte ? b[op_pos + 4'd1] : op0;
        modrm_pos = op_pos + (two_byte ? 4'd2 : 4'd1);
        modrm     = b[modrm_pos];
        sib       = b[modrm_pos + 4'd1];
        mod       = modrm[7:6];
        rm        = modrm[2:0];

        known      = 1'b1;
        need_modrm = 1'b0;
        imm_on     = 1'b0;
        off_on     = 1'b0;
        imm_code   = SIZE_4B;
        if (two_byte) begin
            case (opcode)
                8'h84: imm_on = 1'b1;
                8'haf: need_modrm = 1'b1;
                default: known = 1'b0;
            endcase
        end else begin
            case (opcode) inside
                8'h90: known = 1'b1;
                8'h89, 8'h8b: need_modrm = 1'b1;
                [8'hb8:8'hbf], 8'h05, 8'he8: imm_on = 1'b1;
                8'h81, 8'hc7: begin
                    need_modrm = 1'b1;
                    imm_on     = 1'b1;
                end
                8'h83: begin
                    need_modrm = 1'b1;
                    imm_on     = 1'b1;
                    imm_code   = SIZE_1B;
                end
                8'heb: begin
                    imm_on   = 1'b1;
                    imm_code = SIZE_1B;
                end
                // moffs follows address size, always 32 bit here
                8'ha1, 8'ha3: off_on = 1'b1;
                default: known = 1'b0;
            endcase
        end
        if (opsize && imm_code == SIZE_4B) begin
            imm_code = SIZE_2B;
        end
        sib_on = need_modrm && (mod != 2'b11) && (rm == 3'b100);
    end

    always_comb begin
        fields         = '0;
        fields.illegal = !known;
        if (!known) begin
            // one byte is consumed so the stream stays aligned
            fields.opcode = b[0];
        end else begin
            fields.prefix_present = (pcount != 2'd0);
            fields.prefix_size    = pcount;
            fields.opcode_size    = two_byte;
            fields.opcode         = opcode;
            fields.has_opsize     = opsize;
            fields.rep            = rep;
            fields.imm_present    = imm_on;
            fields.imm_size       = imm_on ? imm_code : SIZE_1B;
            fields.offset_present = off_on;
            fields.offset_size    = off_on ? SIZE_4B : SIZE_1B;
            if (need_modrm) begin
                fields.modrm_present = 1'b1;
                fields.modrm         = modrm;
                fields.sib_present   = sib_on;
                case (mod)
                    2'b01: begin
                        fields.disp_present = 1'b1;
                        fields.disp_size    = DISP_8;
                    end
                    2'b10: begin
                        fields.disp_present = 1'b1;
                        fields.disp_size    = DISP_32;
                    end
                    2'b00: begin
                        // disp32 without base, direct or through SIB
                        if (rm == 3'b101 || (sib_on && sib[2:0] == 3'b101)) begin
                            fields.disp_present = 1'b1;
                            fields.disp_size    = DISP_32;
                        end
                    end
                    default: fields.disp_present = 1'b0;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/instruction_length_decoder.sv */
`default_nettype none

module instruction_length_decoder
    import x86_decode_pkg::*;
(
    input  field_desc_t fields,
    output len_info_t   len
);

    len_t       prefix_l;
    len_t       opcode_l;
    len_t       modrm_l;
    len_t       sib_l;
    len_t       disp_l;
    len_t       imm_l;
    len_t       offset_l;
    len_t       modrm_sib;
    len_t       prefix_op;
    len_t       disp_imm;
    len_t       head;
    len_t       tail;
    logic [4:0] total;

    function automatic len_t size_bytes(logic present, logic [1:0] code);
        if (!present) begin
            return '0;
        end
        case (code)
            SIZE_1B: return 4'd1;
            SIZE_2B: return 4'd2;
            SIZE_4B: return 4'd4;
            default: return 4'd0;
        endcase
    endfunction

    always_comb begin
        prefix_l = fields.prefix_present ? len_t'(fields.prefix_size) : '0;
        opcode_l = fields.opcode_size ? 4'd2 : 4'd1;
        modrm_l  = len_t'(fields.modrm_present);
        sib_l    = len_t'(fields.sib_present);
        disp_l   = !fields.disp_present ? 4'd0 : (fields.disp_size == DISP_8) ? 4'd1 : 4'd4;
        imm_l    = size_bytes(fields.imm_present, fields.imm_size);
        offset_l = size_bytes(fields.offset_present, fields.offset_size);

        // modrm plus sib and prefix plus opcode first, then disp plus imm, then offset
        modrm_sib = modrm_l + sib_l;
        prefix_op = prefix_l + opcode_l;
        disp_imm  = disp_l + imm_l;
        head      = modrm_sib + prefix_op;
        tail      = disp_imm + offset_l;
        total     = {1'b0, head} + {1'b0, tail};

        len.disp_sel = head[2:0];
        len.imm_sel  = head + disp_l;
        len.length   = total[3:0];
    end

    // x86 limit, also keeps the 4-bit sum from wrapping
    always_comb begin
        assert ($isunknown(total) || total <= 5'd15)
            else $error("instruction length %0d over 15 bytes", total);
    end

endmodule

`default_nettype wire

/* rtl/operand_extractor.sv */
`default_nettype none

module operand_extractor
    import x86_decode_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  window_t       window,
    input  count_t        avail,
    input  field_desc_t   fields,
    input  len_info_t     len,
    output logic          advance,
    output logic          out_valid,
    input  logic          out_ready,
    output decoded_insn_t out_insn
);

    byte_t          b [WINDOW_BYTES];
    extract_state_e state;
    logic           can_accept;
    len_t           dpos;
    len_t           ipos;
    logic [31:0]    disp_raw;
    logic [31:0]    imm_raw;
    logic [1:0]     imm_code;
    decoded_insn_t  rec;

    always_comb begin
        for (int i = 0; i < WINDOW_BYTES; i++) begin
            b[i] = window[i*8 +: 8];
        end
    end

    // register free now or drained on this edge
    assign can_accept = (state == EMPTY) || out_ready;
    assign advance    = can_accept && (avail >= count_t'(len.length));
    assign out_valid  = (state == FULL);

    always_comb begin
        dpos     = len_t'(len.disp_sel);
        ipos     = len.imm_sel;
        disp_raw = {b[dpos + 4'd3], b[dpos + 4'd2], b[dpos + 4'd1], b[dpos]};
        imm_raw  = {b[ipos + 4'd3], b[ipos + 4'd2], b[ipos + 4'd1], b[ipos]};
        imm_code = fields.imm_present ? fields.imm_size : fields.offset_size;

        rec           = '0;
        rec.length    = len.length;
        rec.opcode    = fields.opcode;
        rec.two_byte  = fields.opcode_size;
        rec.modrm     = fields.modrm;
        rec.has_modrm = fields.modrm_present;
        rec.illegal   = fields.illegal;
        rec.has_disp  = fields.disp_present;
        rec.has_imm   = fields.imm_present || fields.offset_present;
        if (fields.disp_present) begin
            rec.disp = (fields.disp_size == DISP_8) ?
                       {{24{disp_raw[7]}}, disp_raw[7:0]} : disp_raw;
        end
        if (rec.has_imm) begin
            case (imm_code)
                SIZE_1B: rec.imm = {24'h0, imm_raw[7:0]};
                SIZE_2B: rec.imm = {16'h0, imm_raw[15:0]};
                default: rec.imm = imm_raw;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= EMPTY;
        end else if (advance) begin
            state <= FULL;
        end else if (out_ready) begin
            state <= EMPTY;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            out_insn <= rec;
        end
    end

    // a stalled record must not change under the consumer
    a_hold_when_stalled: assert property (
        @(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_insn))
    ) else $error("out_insn changed while stalled");

endmodule

`default_nettype wire

/* rtl/decode_stage.sv */
`default_nettype none

module decode_stage
    import x86_decode_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          fetch_valid,
    input  chunk_t        fetch_chunk,
    output logic          fetch_ready,
    output logic          out_valid,
    input  logic          out_ready,
    output decoded_insn_t out_insn
);

    window_t     window;
    count_t      avail;
    field_desc_t fields;
    len_info_t   len;
    logic        advance;

    fetch_queue fetch_queue_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .fetch_chunk (fetch_chunk),
        .fetch_ready (fetch_ready),
        .advance     (advance),
        .length      (len.length),
        .window      (window),
        .avail       (avail)
    );

    // decode path is combinational up to the extractor register
    field_decoder field_decoder_i (
        .window (window),
        .avail  (avail),
        .fields (fields)
    );

    instruction_length_decoder instruction_length_decoder_i (
        .fields (fields),
        .len    (len)
    );

    operand_extractor operand_extractor_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .window    (window),
        .avail     (avail),
        .fields    (fields),
        .len       (len),
        .advance   (advance),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_insn  (out_insn)
    );

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD = 10
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // 20 unit period
    always begin
        #HALF_PERIOD;
        clk = ~clk;
    end

endmodule

`default_nettype wire

/* testbench/decode_stage_tb.sv */
`default_nettype none

module decode_stage_tb
    import x86_decode_pkg::*;
;

    localparam int MAX_INSN   = 2048;
    localparam int MAX_CHUNKS = 1024;

    logic          clk;
    logic          rst_n;
    logic          fetch_valid;
    chunk_t        fetch_chunk;
    logic          fetch_ready;
    logic          out_valid;
    logic          out_ready;
    decoded_insn_t out_insn;

    integer        seed = 32'hbf0d5935;
    decoded_insn_t exp_mem [MAX_INSN];
    decoded_insn_t exp_head;
    int            n_insn = 0;
    int            exp_idx;
    chunk_t        chunks [MAX_CHUNKS];
    int            n_chunks = 0;
    chunk_t        cur = '0;
    int            fill = 0;
    byte_t         ib [16];
    int            ib_n;
    decoded_insn_t er;
    int            bp_start = MAX_INSN;
    logic          composed = 1'b0;
    logic          saw_full = 1'b0;
    logic          stalled_once = 1'b0;
    int            stall_left = 0;

    byte_t pfx_list [8] = '{8'h26, 8'h2e, 8'h36, 8'h3e, 8'h64, 8'h65, 8'hf2, 8'hf3};
    byte_t bad_ops [6]  = '{8'h00, 8'h40, 8'hcc, 8'hf4, 8'hc3, 8'h8d};

    tb_clock_gen clock_gen_i (
        .clk (clk)
    );

    decode_stage decode_stage_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .fetch_chunk (fetch_chunk),
        .fetch_ready (fetch_ready),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_insn    (out_insn)
    );

    function automatic int rnd(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [31:0] zext(logic [31:0] v, int n);
        if (n == 1) begin
            return {24'h0, v[7:0]};
        end
        if (n == 2) begin
            return {16'h0, v[15:0]};
        end
        return v;
    endfunction

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic put(byte_t v);
        ib[ib_n] = v;
        ib_n++;
    endtask

    task automatic put_le(logic [31:0] v, int n);
        for (int i = 0; i < n; i++) begin
            put(v[i*8 +: 8]);
        end
    endtask

    task automatic push_record(decoded_insn_t r);
        exp_mem[n_insn] = r;
        n_insn++;
    endtask

    task automatic flush_chunk();
        chunks[n_chunks] = cur;
        n_chunks++;
        cur  = '0;
        fill = 0;
    endtask

    // fill the rest of the chunk with nops so no instruction straddles chunks
    task automatic pad_chunk();
        decoded_insn_t nop;
        nop        = '0;
        nop.length = 4'd1;
        nop.opcode = 8'h90;
        while (fill < CHUNK_BYTES) begin
            cur[fill*8 +: 8] = 8'h90;
            fill++;
            push_record(nop);
        end
        flush_chunk();
    endtask

    task automatic emit();
        if (fill + ib_n > CHUNK_BYTES) begin
            pad_chunk();
        end
        for (int i = 0; i < ib_n; i++) begin
            cur[fill*8 +: 8] = ib[i];
            fill++;
        end
        er.length = len_t'(ib_n);
        push_record(er);
        if (fill == CHUNK_BYTES) begin
            flush_chunk();
        end
    endtask

    task automatic add_prefixes(int n, bit use66);
        for (int i = 0; i < n; i++) begin
            if (i == 0 && use66) begin
                put(8'h66);
            end else begin
                put(pfx_list[rnd(8)]);
            end
        end
    endtask

    // no modrm forms: 90, b8+r, 05, e8, eb, 0f 84
    task automatic make_simple(int kind, int npfx, bit use66);
        logic [31:0] v;
        int          isz;
        ib_n = 0;
        er   = '0;
        v    = $random(seed);
        isz  = use66 ? 2 : 4;
        add_prefixes(npfx, use66);
        case (kind)
            0: er.opcode = 8'h90;
            1: er.opcode = 8'hb8 + byte_t'(rnd(8));
            2: er.opcode = 8'h05;
            3: er.opcode = 8'he8;
            4: begin
                er.opcode = 8'heb;
                isz       = 1;
            end
            default: begin
                put(8'h0f);
                er.opcode   = 8'h84;
                er.two_byte = 1'b1;
            end
        endcase
        put(er.opcode);
        if (kind != 0) begin
            put_le(v, isz);
            er.has_imm = 1'b1;
            er.imm     = zext(v, isz);
        end
        emit();
    endtask

    // 89, 8b, 0f af with every mod/rm and sib base
    task automatic make_modrm(int kind, logic [1:0] md, logic [2:0] rm, logic [2:0] base);
        logic [31:0] v;
        int          dsz;
        ib_n = 0;
        er   = '0;
        v    = $random(seed);
        dsz  = 0;
        if (kind == 2) begin
            put(8'h0f);
            er.two_byte = 1'b1;
            er.opcode   = 8'haf;
        end else begin
            er.opcode = (kind == 0) ? 8'h89 : 8'h8b;
        end
        put(er.opcode);
        er.modrm     = {md, 3'(rnd(8)), rm};
        er.has_modrm = 1'b1;
        put(er.modrm);
        if (md != 2'b11 && rm == 3'b100) begin
            put({2'(rnd(4)), 3'(rnd(8)), base});
            if (md == 2'b00 && base == 3'b101) begin
                dsz = 4;
            end
        end
        if (md == 2'b01) begin
            dsz = 1;
        end else if (md == 2'b10 || (md == 2'b00 && rm == 3'b101)) begin
            dsz = 4;
        end
        if (dsz > 0) begin
            put_le(v, dsz);
            er.has_disp = 1'b1;
            er.disp     = (dsz == 1) ? {{24{v[7]}}, v[7:0]} : v;
        end
        emit();
    endtask

    // 81, 83, c7 in register form, a1/a3 moffs32
    task automatic make_imm(int kind, bit use66);
        logic [31:0] v;
        int          isz;
        ib_n = 0;
        er   = '0;
        v    = $random(seed);
        isz  = use66 ? 2 : 4;
        if (use66) begin
            put(8'h66);
        end
        case (kind)
            0: er.opcode = 8'h81;
            1: er.opcode = 8'h83;
            2: er.opcode = 8'hc7;
            3: er.opcode = 8'ha1;
            default: er.opcode = 8'ha3;
        endcase
        put(er.opcode);
        if (kind == 1) begin
            isz = 1;
        end else if (kind >= 3) begin
            isz = 4;
        end
        if (kind <= 2) begin
            er.modrm     = {2'b11, 3'(rnd(8)), 3'(rnd(8))};
            er.has_modrm = 1'b1;
            put(er.modrm);
        end
        put_le(v, isz);
        er.has_imm = 1'b1;
        er.imm     = zext(v, isz);
        emit();
    endtask

    task automatic make_illegal(byte_t op);
        ib_n       = 0;
        er         = '0;
        er.opcode  = op;
        er.illegal = 1'b1;
        put(op);
        emit();
    endtask

    task automatic make_random();
        int kind;
        int npfx;
        case (rnd(4))
            0: begin
                kind = rnd(6);
                npfx = rnd(kind == 5 ? 3 : 4);
                make_simple(kind, npfx, (npfx > 0) && (rnd(2) == 1));
            end
            1: make_modrm(rnd(3), 2'(rnd(4)), 3'(rnd(8)), 3'(rnd(8)));
            2: make_imm(rnd(5), rnd(2) == 1);
            default: make_illegal(bad_ops[rnd(6)]);
        endcase
    endtask

    task automatic compose();
        for (int k = 0; k < 6; k++) begin
            for (int p = 0; p < 4; p++) begin
                if (!(k == 5 && p == 3)) begin
                    make_simple(k, p, (p > 0) && (k == 1 || p == 2));
                end
            end
        end
        for (int k = 0; k < 3; k++) begin
            for (int md = 0; md < 4; md++) begin
                for (int rm = 0; rm < 8; rm++) begin
                    if (md != 3 && rm == 4) begin
                        for (int bs = 0; bs < 8; bs++) begin
                            make_modrm(k, 2'(md), 3'(rm), 3'(bs));
                        end
                    end else begin
                        make_modrm(k, 2'(md), 3'(rm), 3'b000);
                    end
                end
            end
        end
        for (int k = 0; k < 5; k++) begin
            for (int u = 0; u < 2; u++) begin
                make_imm(k, u == 1);
                make_imm(k, u == 1);
            end
        end
        // each bad opcode followed by a legal one to check alignment
        for (int i = 0; i < 6; i++) begin
            make_illegal(bad_ops[i]);
            make_simple(2, 0, 1'b0);
        end
        bp_start = n_insn;
        repeat (200) make_random();
        if (fill > 0) begin
            pad_chunk();
        end
    endtask

    assign exp_head = exp_mem[exp_idx];

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_idx <= 0;
        end else if (out_valid && out_ready) begin
            exp_idx <= exp_idx + 1;
        end
    end

    always @(posedge clk) begin
        if (fetch_valid && !fetch_ready) begin
            saw_full <= 1'b1;
        end
    end

    // always ready first, then one long stall, then random
    always @(posedge clk) begin
        if (rst_n) begin
            if (exp_idx < bp_start) begin
                out_ready <= 1'b1;
            end else if (!stalled_once) begin
                stalled_once <= 1'b1;
                stall_left   <= 30;
                out_ready    <= 1'b0;
            end else if (stall_left > 0) begin
                stall_left <= stall_left - 1;
                out_ready  <= 1'b0;
            end else begin
                out_ready <= 1'(rnd(2));
            end
        end
    end

    a_record_match: assert property (
        @(posedge clk) disable iff (!rst_n)
        (out_valid && out_ready) |-> (out_insn == exp_head)
    ) else begin
        $display("** Error: out_insn = 0x%h, expected 0x%h (record %0d)",
                 $sampled(out_insn), $sampled(exp_head), $sampled(exp_idx));
        abort_run();
    end

    a_no_extra: assert property (
        @(posedge clk) disable iff (!rst_n)
        (out_valid && out_ready) |-> (exp_idx < n_insn)
    ) else begin
        $display("DUT delivered more records than instructions were sent");
        abort_run();
    end

    a_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_insn))
    ) else begin
        $display("stalled record was dropped or changed before it was taken");
        abort_run();
    end

    a_reset_idle: assert property (
        @(posedge clk) (!rst_n || $rose(rst_n)) |-> (!out_valid && fetch_ready)
    ) else begin
        $display("** Error: out_valid = 0x%h, fetch_ready = 0x%h around reset",
                 $sampled(out_valid), $sampled(fetch_ready));
        abort_run();
    end

    initial begin
        wait (composed);
        repeat (40 * n_insn + 100) @(posedge clk);
        $display("timeout with %0d of %0d records seen", exp_idx, n_insn);
        abort_run();
    end

    initial begin
        rst_n       = 1'b0;
        fetch_valid = 1'b0;
        fetch_chunk = '0;
        out_ready   = 1'b0;
        compose();
        composed = 1'b1;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        for (int c = 0; c < n_chunks; c++) begin
            fetch_valid <= 1'b1;
            fetch_chunk <= chunks[c];
            do begin
                @(posedge clk);
            end while (!fetch_ready);
        end
        fetch_valid <= 1'b0;
        wait (exp_idx == n_insn);
        repeat (10) @(posedge clk);
        if (exp_idx == n_insn && saw_full) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("queue never filled or record count off at the end");
            abort_run();
        end
    end

endmodule

`default_nettype wire

/* flist.f */
rtl/x86_decode_pkg.sv
rtl/fetch_queue.sv
rtl/field_decoder.sv
rtl/instruction_length_decoder.sv
rtl/operand_extractor.sv
rtl/decode_stage.sv
testbench/tb_clock_gen.sv
testbench/decode_stage_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    --top-module decode_stage_tb -f flist.f -o decode_stage_sim &&
./obj_dir/decode_stage_sim | tee /dev/stderr | grep -q "Simulation finished: PASS" &&
echo "run passed" || { echo "run failed"; exit 1; }
